/* verilog/fpu_pkg.sv */
package fpu_pkg;

    // operand and result word, IEEE single or two's-complement integer
    typedef logic [31:0] word_t;

    typedef logic [2:0] func3_t;
    typedef logic [6:0] func7_t;

    // operation field codes
    localparam func7_t FUNC7_FSGNJ = 7'b0010000;
    localparam func7_t FUNC7_FCOMP = 7'b1010000;
    localparam func7_t FUNC7_ITOF  = 7'b1101000;
    localparam func7_t FUNC7_FMVI  = 7'b1110000;
    localparam func7_t FUNC7_IMVF  = 7'b1111000;

    // sign injection variants
    localparam func3_t FUNC3_SGNJ  = 3'b000;
    localparam func3_t FUNC3_SGNJN = 3'b001;
    localparam func3_t FUNC3_SGNJX = 3'b010;

    // comparison variants
    localparam func3_t FUNC3_FLE = 3'b000;
    localparam func3_t FUNC3_FLT = 3'b001;
    localparam func3_t FUNC3_FEQ = 3'b010;

    // one-hot unit order, bit positions below
    typedef logic [4:0] unit_sel_t;

    localparam int UNIT_FSGNJ   = 0;
    localparam int UNIT_FCOMP   = 1;
    localparam int UNIT_ITOF    = 2;
    localparam int UNIT_MOVE    = 3;
    localparam int UNIT_ILLEGAL = 4;

    typedef struct packed {
        unit_sel_t sel;
        func3_t    func3;
    } fpu_dispatch_t;

    // what every execute unit hands back
    typedef struct packed {
        logic  done;
        word_t data;
    } unit_result_t;

    typedef enum logic {
        ITOF_IDLE,
        ITOF_NORM
    } itof_state_t;

endpackage

/* verilog/fpu_decode.sv */
module fpu_decode import fpu_pkg::*; (
    input  logic          dispatch_ok,
    input  func7_t        func7,
    input  func3_t        func3,
    output fpu_dispatch_t dispatch
);

    unit_sel_t sel;

    // one order bit per func7 code
    always_comb begin
        sel = '0;
        if (dispatch_ok) begin
            case (func7)
                FUNC7_FSGNJ: begin
                    sel[UNIT_FSGNJ] = 1'b1;
                end
                FUNC7_FCOMP: begin
                    sel[UNIT_FCOMP] = 1'b1;
                end
                FUNC7_ITOF: begin
                    sel[UNIT_ITOF] = 1'b1;
                end
                // both raw moves share one path
                FUNC7_FMVI, FUNC7_IMVF: begin
                    sel[UNIT_MOVE] = 1'b1;
                end
                // any other code takes the illegal path
                default: begin
                    sel[UNIT_ILLEGAL] = 1'b1;
                end
            endcase
        end
    end

    always_comb begin
        dispatch.sel   = sel;
        dispatch.func3 = func3;
    end

endmodule

/* verilog/fsgnj.sv */
module fsgnj import fpu_pkg::*; (
    input  logic         order,
    input  func3_t       func3,
    input  word_t        rs1,
    input  word_t        rs2,
    output unit_result_t result
);

    logic sign;

    // pick the sign, magnitude always from rs1
    always_comb begin
        case (func3)
            FUNC3_SGNJN: begin
                sign = ~rs2[31];
            end
            FUNC3_SGNJX: begin
                sign = rs1[31] ^ rs2[31];
            end
            default: begin
                sign = rs2[31];
            end
        endcase
    end

    // single cycle, done with the order
    always_comb begin
        result.done = order;
        result.data = {sign, rs1[30:0]};
    end

endmodule

/* verilog/fcomp.sv */
module fcomp import fpu_pkg::*; (
    input  logic         order,
    input  func3_t       func3,
    input  word_t        rs1,
    input  word_t        rs2,
    output unit_result_t result
);

    logic rs1_nan;
    logic rs2_nan;
    logic both_zero;
    logic eq;
    logic lt;
    logic cmp;

    always_comb begin
        rs1_nan   = (rs1[30:23] == 8'hff) && (rs1[22:0] != 23'd0);
        rs2_nan   = (rs2[30:23] == 8'hff) && (rs2[22:0] != 23'd0);
        // +0 and -0 compare equal
        both_zero = (rs1[30:0] == 31'd0) && (rs2[30:0] == 31'd0);
        eq        = both_zero || (rs1 == rs2);
    end

    // sign-magnitude ordering
    always_comb begin
        case ({rs1[31], rs2[31]})
            2'b00: begin
                lt = rs1[30:0] < rs2[30:0];
            end
            2'b11: begin
                lt = rs1[30:0] > rs2[30:0];
            end
            2'b10: begin
                lt = ~both_zero;
            end
            default: begin
                lt = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (func3)
            FUNC3_FLE: cmp = lt | eq;
            FUNC3_FLT: cmp = lt;
            FUNC3_FEQ: cmp = eq;
            default:   cmp = 1'b0;
        endcase
        // any NaN makes every comparison false
        if (rs1_nan || rs2_nan) begin
            cmp = 1'b0;
        end
    end

    always_comb begin
        result.done = order;
        result.data = {31'd0, cmp};
    end

endmodule

/* verilog/itof.sv */
module itof import fpu_pkg::*; #(
    parameter int NORM_MAX = 31
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         order,
    input  word_t        rs1,
    output logic         accepted,
    output unit_result_t result
);

    localparam int CNT_W = $clog2(NORM_MAX + 1);

    itof_state_t      state;
    logic [CNT_W-1:0] count;
    word_t            mag;
    logic             sign;
    logic             norm_end;
    logic [7:0]       exponent;

    // only takes an order when idle
    always_comb begin
        accepted = order && (state == ITOF_IDLE);
        norm_end = (state == ITOF_NORM) && ((mag == '0) || mag[31]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ITOF_IDLE;
            count <= '0;
        end else begin
            case (state)
                ITOF_IDLE: begin
                    if (accepted) begin
                        state <= ITOF_NORM;
                        count <= '0;
                    end
                end
                ITOF_NORM: begin
                    if (norm_end) begin
                        state <= ITOF_IDLE;
                    end else begin
                        count <= count + CNT_W'(1);
                    end
                end
                default: begin
                    state <= ITOF_IDLE;
                end
            endcase
        end
    end

    // magnitude register, shifted left until bit 31 is set
    always_ff @(posedge clk) begin
        if (accepted) begin
            sign <= rs1[31];
            mag  <= rs1[31] ? word_t'(~rs1 + 32'd1) : rs1;
        end else if ((state == ITOF_NORM) && !norm_end) begin
            mag <= mag << 1;
        end
    end

    // bias 127 plus 31 for the top bit
    always_comb begin
        exponent = 8'd158 - 8'(count);
    end

    // mantissa truncated, zero input gives +0
    always_comb begin
        result.done = norm_end;
        if (mag == '0) begin
            result.data = '0;
        end else begin
            result.data = {sign, exponent, mag[30:8]};
        end
    end

    // input narrower than NORM_MAX bits must never need more shifts
    a_norm_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == ITOF_NORM) && !norm_end |-> count < NORM_MAX
    ) else $error("itof: normalization count exceeds NORM_MAX");

endmodule

/* verilog/fpu_result.sv */
module fpu_result import fpu_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  fpu_dispatch_t dispatch,
    input  word_t         rs1,
    input  unit_result_t  fsgnj_res,
    input  unit_result_t  fcomp_res,
    input  unit_result_t  itof_res,
    input  logic          itof_accepted,
    output logic          accepted,
    output logic          done,
    output word_t         rd
);

    logic  move_done;
    logic  illegal_done;
    word_t rd_q;
    word_t rd_next;

    // moves and illegal orders finish here at once
    always_comb begin
        move_done    = dispatch.sel[UNIT_MOVE];
        illegal_done = dispatch.sel[UNIT_ILLEGAL];
    end

    // single-cycle units accept and finish together
    always_comb begin
        accepted = fsgnj_res.done | fcomp_res.done | itof_accepted
                 | move_done | illegal_done;
        done     = fsgnj_res.done | fcomp_res.done | itof_res.done
                 | move_done | illegal_done;
    end

    always_comb begin
        if (fsgnj_res.done) begin
            rd_next = fsgnj_res.data;
        end else if (fcomp_res.done) begin
            rd_next = fcomp_res.data;
        end else if (itof_res.done) begin
            rd_next = itof_res.data;
        end else if (move_done) begin
            rd_next = rs1;
        end else if (illegal_done) begin
            rd_next = '0;
        end else begin
            rd_next = rd_q;
        end
    end

    assign rd = rd_next;

    // last result stays visible until the next done
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_q <= '0;
        end else if (done) begin
            rd_q <= rd_next;
        end
    end

    a_one_done: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({fsgnj_res.done, fcomp_res.done, itof_res.done, move_done, illegal_done})
    ) else $error("fpu_result: more than one unit done");

endmodule

/* verilog/fpu.sv */
module fpu import fpu_pkg::*; #(
    parameter int NORM_MAX = 31
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   order,
    input  func3_t func3,
    input  func7_t func7,
    input  word_t  rs1,
    input  word_t  rs2,
    output logic   accepted,
    output logic   done,
    output word_t  rd
);

    logic          busy;
    logic          dispatch_ok;
    logic          itof_accepted;
    fpu_dispatch_t dispatch;
    unit_result_t  fsgnj_res;
    unit_result_t  fcomp_res;
    unit_result_t  itof_res;

    // new orders only go out while nothing is in flight
    assign dispatch_ok = ~busy & order;

    // busy covers multi-cycle work, cleared in the done cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (busy) begin
            busy <= ~done;
        end else begin
            busy <= dispatch_ok & ~done;
        end
    end

    fpu_decode u_decode (
        .dispatch_ok (dispatch_ok),
        .func7       (func7),
        .func3       (func3),
        .dispatch    (dispatch)
    );

    fsgnj u_fsgnj (
        .order  (dispatch.sel[UNIT_FSGNJ]),
        .func3  (dispatch.func3),
        .rs1    (rs1),
        .rs2    (rs2),
        .result (fsgnj_res)
    );

    fcomp u_fcomp (
        .order  (dispatch.sel[UNIT_FCOMP]),
        .func3  (dispatch.func3),
        .rs1    (rs1),
        .rs2    (rs2),
        .result (fcomp_res)
    );

    itof #(
        .NORM_MAX (NORM_MAX)
    ) u_itof (
        .clk      (clk),
        .arst_n   (arst_n),
        .order    (dispatch.sel[UNIT_ITOF]),
        .rs1      (rs1),
        .accepted (itof_accepted),
        .result   (itof_res)
    );

    fpu_result u_result (
        .clk           (clk),
        .arst_n        (arst_n),
        .dispatch      (dispatch),
        .rs1           (rs1),
        .fsgnj_res     (fsgnj_res),
        .fcomp_res     (fcomp_res),
        .itof_res      (itof_res),
        .itof_accepted (itof_accepted),
        .accepted      (accepted),
        .done          (done),
        .rd            (rd)
    );

    // a done needs either work in flight or an order taken now
    a_done_owned: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> busy || dispatch_ok
    ) else $error("fpu: done without an operation");

endmodule

/* bench/fpu_tb.sv */
module fpu_tb import fpu_pkg::*; ();

    localparam int ACCEPT_LIMIT = 10;
    localparam int DONE_LIMIT   = 40;

    logic   clk;
    logic   arst_n;
    logic   order;
    func3_t func3;
    func7_t func7;
    word_t  rs1;
    word_t  rs2;
    logic   accepted;
    logic   done;
    word_t  rd;

    // stimulus table, one entry per index
    string  name_q[$];
    func7_t f7_q[$];
    func3_t f3_q[$];
    word_t  a_q[$];
    word_t  b_q[$];
    word_t  exp_q[$];
    int     cyc_q[$];

    int     errors = 0;
    int     checks = 0;
    integer seed = 32'ha055;

    fpu #(
        .NORM_MAX (31)
    ) dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .order    (order),
        .func3    (func3),
        .func7    (func7),
        .rs1      (rs1),
        .rs2      (rs2),
        .accepted (accepted),
        .done     (done),
        .rd       (rd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // position of the highest set bit, -1 for zero
    function automatic int leading_one(input word_t m);
        int p;
        p = -1;
        for (int i = 0; i < 32; i++) begin
            if (m[i]) begin
                p = i;
            end
        end
        return p;
    endfunction

    // truncating int to float: exponent 127 plus top bit position
    function automatic word_t itof_expect(input word_t v);
        word_t m;
        word_t aligned;
        int    p;
        m = v[31] ? (32'd0 - v) : v;
        p = leading_one(m);
        if (p < 0) begin
            return '0;
        end
        aligned = m << (31 - p);
        return {v[31], 8'(127 + p), aligned[30:8]};
    endfunction

    // cycles from accepted to done
    function automatic int cycles_expect(input func7_t f7, input word_t v);
        word_t m;
        int    p;
        if (f7 != FUNC7_ITOF) begin
            return 0;
        end
        m = v[31] ? (32'd0 - v) : v;
        p = leading_one(m);
        if (p < 0) begin
            return 1;
        end
        return 32 - p;
    endfunction

    task automatic add_entry(input string name, input func7_t f7, input func3_t f3,
                             input word_t a, input word_t b, input word_t exp);
        name_q.push_back(name);
        f7_q.push_back(f7);
        f3_q.push_back(f3);
        a_q.push_back(a);
        b_q.push_back(b);
        exp_q.push_back(exp);
        cyc_q.push_back(cycles_expect(f7, a));
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic build_table();
        word_t v;
        int    sh;
        // sign injection, 1.5 / -pi against mixed signs
        add_entry("fsgnj pos neg", FUNC7_FSGNJ, FUNC3_SGNJ, 32'h3fc00000, 32'hc0000000,
                  32'hbfc00000);
        add_entry("fsgnjn pos neg", FUNC7_FSGNJ, FUNC3_SGNJN, 32'h3fc00000, 32'hc0000000,
                  32'h3fc00000);
        add_entry("fsgnjx pos neg", FUNC7_FSGNJ, FUNC3_SGNJX, 32'h3fc00000, 32'hc0000000,
                  32'hbfc00000);
        add_entry("fsgnj neg pos", FUNC7_FSGNJ, FUNC3_SGNJ, 32'hc0490fdb, 32'h40000000,
                  32'h40490fdb);
        add_entry("fsgnjn neg pos", FUNC7_FSGNJ, FUNC3_SGNJN, 32'hc0490fdb, 32'h40000000,
                  32'hc0490fdb);
        add_entry("fsgnjx neg neg", FUNC7_FSGNJ, FUNC3_SGNJX, 32'hc0490fdb, 32'hc0000000,
                  32'h40490fdb);
        // comparisons
        add_entry("flt 1 2", FUNC7_FCOMP, FUNC3_FLT, 32'h3f800000, 32'h40000000, 32'd1);
        add_entry("flt 2 1", FUNC7_FCOMP, FUNC3_FLT, 32'h40000000, 32'h3f800000, 32'd0);
        add_entry("fle 1 1", FUNC7_FCOMP, FUNC3_FLE, 32'h3f800000, 32'h3f800000, 32'd1);
        add_entry("feq 1 1", FUNC7_FCOMP, FUNC3_FEQ, 32'h3f800000, 32'h3f800000, 32'd1);
        add_entry("feq 1 2", FUNC7_FCOMP, FUNC3_FEQ, 32'h3f800000, 32'h40000000, 32'd0);
        add_entry("flt -2 -1", FUNC7_FCOMP, FUNC3_FLT, 32'hc0000000, 32'hbf800000, 32'd1);
        add_entry("flt -1 -2", FUNC7_FCOMP, FUNC3_FLT, 32'hbf800000, 32'hc0000000, 32'd0);
        add_entry("fle -1 1", FUNC7_FCOMP, FUNC3_FLE, 32'hbf800000, 32'h3f800000, 32'd1);
        add_entry("feq +0 -0", FUNC7_FCOMP, FUNC3_FEQ, 32'h00000000, 32'h80000000, 32'd1);
        add_entry("fle -0 +0", FUNC7_FCOMP, FUNC3_FLE, 32'h80000000, 32'h00000000, 32'd1);
        add_entry("flt -0 +0", FUNC7_FCOMP, FUNC3_FLT, 32'h80000000, 32'h00000000, 32'd0);
        add_entry("feq nan nan", FUNC7_FCOMP, FUNC3_FEQ, 32'h7fc00000, 32'h7fc00000, 32'd0);
        add_entry("fle nan 1", FUNC7_FCOMP, FUNC3_FLE, 32'h7fc00000, 32'h3f800000, 32'd0);
        add_entry("flt 1 nan", FUNC7_FCOMP, FUNC3_FLT, 32'h3f800000, 32'hffc00001, 32'd0);
        // integer to float, truncating
        add_entry("itof 0", FUNC7_ITOF, 3'd0, 32'd0, 32'd0, 32'h00000000);
        add_entry("itof 1", FUNC7_ITOF, 3'd0, 32'd1, 32'd0, 32'h3f800000);
        add_entry("itof -1", FUNC7_ITOF, 3'd0, 32'hffffffff, 32'd0, 32'hbf800000);
        add_entry("itof -7", FUNC7_ITOF, 3'd0, 32'hfffffff9, 32'd0, 32'hc0e00000);
        add_entry("itof min", FUNC7_ITOF, 3'd0, 32'h80000000, 32'd0, 32'hcf000000);
        add_entry("itof max", FUNC7_ITOF, 3'd0, 32'h7fffffff, 32'd0, 32'h4effffff);
        add_entry("itof 2^24+1", FUNC7_ITOF, 3'd0, 32'h01000001, 32'd0, 32'h4b800000);
        // shifted random values give a spread of leading zeros
        for (int i = 0; i < 8; i++) begin
            v  = $random(seed);
            sh = $random(seed) & 31;
            v  = $signed(v) >>> sh;
            add_entry($sformatf("itof random %0d", i), FUNC7_ITOF, 3'd0, v, 32'd0,
                      itof_expect(v));
        end
        // raw moves and an unknown code
        add_entry("fmv.x.w", FUNC7_FMVI, 3'd0, 32'hdeadbeef, 32'h12345678, 32'hdeadbeef);
        add_entry("fmv.w.x", FUNC7_IMVF, 3'd0, 32'h7fc00001, 32'h0, 32'h7fc00001);
        add_entry("illegal", 7'b0000001, 3'd0, 32'h3f800000, 32'h40000000, 32'd0);
    endtask

    task automatic apply_entry(input int idx);
        int waited;
        int lat;
        @(negedge clk);
        func7 = f7_q[idx];
        func3 = f3_q[idx];
        rs1   = a_q[idx];
        rs2   = b_q[idx];
        order = 1'b1;
        waited = 0;
        #1;
        while (!accepted && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!accepted) begin
            errors++;
            $display("%s: order was never accepted", name_q[idx]);
        end else begin
            lat = 0;
            // order stays high, a busy unit must not take it again
            while (!done && lat < DONE_LIMIT) begin
                @(negedge clk);
                #1;
                lat++;
                if (accepted) begin
                    errors++;
                    $display("%s: order accepted again while busy", name_q[idx]);
                end
            end
            if (!done) begin
                errors++;
                $display("%s: no done within %0d cycles", name_q[idx], DONE_LIMIT);
            end else begin
                check_value(name_q[idx], exp_q[idx], rd);
                check_value({name_q[idx], " latency"}, word_t'(cyc_q[idx]), word_t'(lat));
            end
        end
        @(negedge clk);
        order = 1'b0;
        // result must hold with nothing pending
        for (int k = 0; k < 2; k++) begin
            #1;
            check_value({name_q[idx], " hold"}, exp_q[idx], rd);
            if (done) begin
                errors++;
                $display("%s: done pulsed with no order", name_q[idx]);
            end
            @(negedge clk);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        order  = 1'b0;
        func3  = '0;
        func7  = '0;
        rs1    = '0;
        rs2    = '0;
        build_table();
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        #1;
        check_value("reset accepted", 32'd0, {31'd0, accepted});
        check_value("reset done", 32'd0, {31'd0, done});
        check_value("reset rd", 32'd0, rd);
        for (int i = 0; i < name_q.size(); i++) begin
            apply_entry(i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* fpu.f */
verilog/fpu_pkg.sv
verilog/fpu_decode.sv
verilog/fsgnj.sv
verilog/fcomp.sv
verilog/itof.sv
verilog/fpu_result.sv
verilog/fpu.sv
bench/fpu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module fpu_tb -f fpu.f \
		--Mdir obj_dir -o fpu_sim
	out=$$(./obj_dir/fpu_sim); echo "$$out"; \
		echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
